/* source/ex_pkg.sv */
/*
  Shared definitions for the execute stage: data widths, ALU and multiplier
  opcodes, multiplier FSM states and the ID/EX, EX/WB and controller structs
*/
package ex_pkg;

  // Data path and register file widths
  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned SHAMT_W    = $clog2(XLEN);

  // Multiplier split into 16-bit halves, partial products carry a sign bit each
  localparam int unsigned MUL_HALF_W = XLEN / 2;
  localparam int unsigned MUL_PP_W   = 2 * (MUL_HALF_W + 1);
  localparam int unsigned MUL_PROD_W = 2 * XLEN;

  // ALU operations, the last four are the branch compares
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE
  } alu_op_e;

  // Multiplier operations
  typedef enum logic [1:0] {MUL_LO, MUL_HI_SS, MUL_HI_UU} mul_op_e;

  // Multiplier FSM
  typedef enum logic [1:0] {MUL_IDLE, MUL_SUM, MUL_DONE} mul_state_e;

  // Decode to execute
  typedef struct packed {
    logic                  instr_valid;
    logic                  alu_en;
    logic                  mul_en;
    logic                  bch;
    logic                  rf_we;
    alu_op_e               alu_operator;
    mul_op_e               mul_operator;
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       operand_b;
    logic [XLEN-1:0]       operand_c;       // branch target
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [XLEN-1:0]       pc;
  } id_ex_t;

  // Execute to writeback
  typedef struct packed {
    logic                  instr_valid;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [XLEN-1:0]       rf_wdata;
    logic [XLEN-1:0]       pc;
    logic                  bch_taken;
  } ex_wb_t;

  // Controller levels for this stage
  typedef struct packed {
    logic kill_ex;
    logic halt_ex;
  } ctrl_fsm_t;

endpackage

/* source/ex_alu.sv */
/*
  Single-cycle ALU: add/sub, logic, shifts, set-less-than and branch compares
  sharing one adder for subtract and compare
*/
`timescale 1ns/10ps

module ex_alu (
  input  ex_pkg::alu_op_e           operator_i,
  input  logic [ex_pkg::XLEN-1:0]   operand_a_i,
  input  logic [ex_pkg::XLEN-1:0]   operand_b_i,
  output logic [ex_pkg::XLEN-1:0]   result_o,
  output logic                      cmp_result_o
);

  logic                         is_sub;
  logic [ex_pkg::XLEN-1:0]      adder_b;
  logic [ex_pkg::XLEN:0]        adder_sum;
  logic                         lt_s;
  logic                         lt_u;
  logic                         eq;
  logic [ex_pkg::SHAMT_W-1:0]   shamt;

  // Everything but ADD goes through the adder as a - b
  assign is_sub  = (operator_i != ex_pkg::ALU_ADD);
  assign adder_b = operand_b_i ^ {ex_pkg::XLEN{is_sub}};

  // Extra top bit keeps the carry out for the unsigned compare
  assign adder_sum = {1'b0, operand_a_i} + {1'b0, adder_b} + {{ex_pkg::XLEN{1'b0}}, is_sub};

  // No carry out of a - b means a borrow, so a < b unsigned
  assign lt_u = ~adder_sum[ex_pkg::XLEN];
  // Signs differ: the negative one is smaller, else the difference sign decides
  assign lt_s = (operand_a_i[ex_pkg::XLEN-1] != operand_b_i[ex_pkg::XLEN-1]) ?
                operand_a_i[ex_pkg::XLEN-1] : adder_sum[ex_pkg::XLEN-1];
  assign eq   = (adder_sum[ex_pkg::XLEN-1:0] == '0);

  assign shamt = operand_b_i[ex_pkg::SHAMT_W-1:0];

  // Branch condition, only the four branch opcodes raise it
  always_comb begin
    case (operator_i)
      ex_pkg::ALU_EQ: cmp_result_o = eq;
      ex_pkg::ALU_NE: cmp_result_o = ~eq;
      ex_pkg::ALU_LT: cmp_result_o = lt_s;
      ex_pkg::ALU_GE: cmp_result_o = ~lt_s;
      default:        cmp_result_o = 1'b0;
    endcase
  end

  // Result mux
  always_comb begin
    case (operator_i)
      ex_pkg::ALU_ADD,
      ex_pkg::ALU_SUB:  result_o = adder_sum[ex_pkg::XLEN-1:0];
      ex_pkg::ALU_AND:  result_o = operand_a_i & operand_b_i;
      ex_pkg::ALU_OR:   result_o = operand_a_i | operand_b_i;
      ex_pkg::ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      ex_pkg::ALU_SLL:  result_o = operand_a_i << shamt;
      ex_pkg::ALU_SRL:  result_o = operand_a_i >> shamt;
      ex_pkg::ALU_SRA:  result_o = $unsigned($signed(operand_a_i) >>> shamt);
      ex_pkg::ALU_SLT:  result_o = {{(ex_pkg::XLEN-1){1'b0}}, lt_s};
      ex_pkg::ALU_SLTU: result_o = {{(ex_pkg::XLEN-1){1'b0}}, lt_u};
      // Compares return their branch bit zero-extended
      ex_pkg::ALU_EQ,
      ex_pkg::ALU_NE,
      ex_pkg::ALU_LT,
      ex_pkg::ALU_GE:   result_o = {{(ex_pkg::XLEN-1){1'b0}}, cmp_result_o};
      default:          result_o = '0;
    endcase
  end

endmodule

/* source/ex_mult.sv */
/*
  Multi-cycle 32x32 multiplier: MUL, MULH and MULHU from four registered
  16x16 partial products, with a valid/ready handshake on both sides
*/
`timescale 1ns/10ps

module ex_mult (
  input  logic                      clk,
  input  logic                      rst_n,
  input  ex_pkg::mul_op_e           operator_i,
  input  logic [ex_pkg::XLEN-1:0]   op_a_i,
  input  logic [ex_pkg::XLEN-1:0]   op_b_i,
  input  logic                      valid_i,
  output logic                      ready_o,
  output logic                      valid_o,
  input  logic                      ready_i,
  output logic [ex_pkg::XLEN-1:0]   result_o
);

  localparam int unsigned HW = ex_pkg::MUL_HALF_W;

  ex_pkg::mul_state_e state_q, state_d;

  // Captured operands and operation
  ex_pkg::mul_op_e                  op_q;
  logic [ex_pkg::XLEN-1:0]          op_a_q;
  logic [ex_pkg::XLEN-1:0]          op_b_q;

  // Halves widened to 17 bits, upper halves carry the sign in MULH
  logic                             is_signed;
  logic signed [HW:0]               a_lo, a_hi, b_lo, b_hi;

  logic signed [ex_pkg::MUL_PP_W-1:0] pp_ll_q, pp_lh_q, pp_hl_q, pp_hh_q;
  logic signed [ex_pkg::MUL_PP_W:0]   pp_mid;
  logic signed [ex_pkg::MUL_PROD_W-1:0] product;

  assign is_signed = (op_q == ex_pkg::MUL_HI_SS);

  assign a_lo = {1'b0, op_a_q[HW-1:0]};
  assign b_lo = {1'b0, op_b_q[HW-1:0]};
  assign a_hi = {is_signed & op_a_q[ex_pkg::XLEN-1], op_a_q[ex_pkg::XLEN-1:HW]};
  assign b_hi = {is_signed & op_b_q[ex_pkg::XLEN-1], op_b_q[ex_pkg::XLEN-1:HW]};

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ex_pkg::MUL_IDLE: if (valid_i) state_d = ex_pkg::MUL_SUM;
      // Dropped valid means the instruction was killed or halted
      ex_pkg::MUL_SUM:  state_d = valid_i ? ex_pkg::MUL_DONE : ex_pkg::MUL_IDLE;
      ex_pkg::MUL_DONE: if (!valid_i || ready_i) state_d = ex_pkg::MUL_IDLE;
      default:          state_d = ex_pkg::MUL_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ex_pkg::MUL_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Operand capture on acceptance, partial products in MUL_SUM
  always_ff @(posedge clk) begin
    if (state_q == ex_pkg::MUL_IDLE && valid_i) begin
      op_q   <= operator_i;
      op_a_q <= op_a_i;
      op_b_q <= op_b_i;
    end
    if (state_q == ex_pkg::MUL_SUM) begin
      pp_ll_q <= a_lo * b_lo;
      pp_lh_q <= a_lo * b_hi;
      pp_hl_q <= a_hi * b_lo;
      pp_hh_q <= a_hi * b_hi;
    end
  end

  // Cross terms share one shift
  assign pp_mid  = pp_lh_q + pp_hl_q;
  assign product = ex_pkg::MUL_PROD_W'(pp_ll_q)
                 + (ex_pkg::MUL_PROD_W'(pp_mid) << HW)
                 + (ex_pkg::MUL_PROD_W'(pp_hh_q) << ex_pkg::XLEN);

  assign result_o = (op_q == ex_pkg::MUL_LO) ? product[ex_pkg::XLEN-1:0]
                                              : product[ex_pkg::MUL_PROD_W-1:ex_pkg::XLEN];

  // Handshake
  assign valid_o = (state_q == ex_pkg::MUL_DONE);
  assign ready_o = ((state_q == ex_pkg::MUL_IDLE) && !valid_i) ||
                   ((state_q == ex_pkg::MUL_DONE) && ready_i);

endmodule

/* source/ex_pipe_ctrl.sv */
/*
  Execute stage control: kill/halt gating, result select, branch outputs,
  stage valid/ready and the EX/WB pipeline register
*/
`timescale 1ns/10ps

module ex_pipe_ctrl (
  input  logic                      clk,
  input  logic                      rst_n,
  input  ex_pkg::id_ex_t            id_ex_pipe_i,
  input  ex_pkg::ctrl_fsm_t         ctrl_fsm_i,
  input  logic                      wb_ready_i,
  input  logic [ex_pkg::XLEN-1:0]   alu_result_i,
  input  logic                      alu_cmp_i,
  input  logic [ex_pkg::XLEN-1:0]   mul_result_i,
  input  logic                      mul_valid_i,
  input  logic                      mul_ready_i,
  output logic                      mul_en_o,
  output logic                      branch_decision_o,
  output logic [ex_pkg::XLEN-1:0]   branch_target_o,
  output logic [ex_pkg::XLEN-1:0]   rf_wdata_o,
  output logic                      ex_valid_o,
  output logic                      ex_ready_o,
  output ex_pkg::ex_wb_t            ex_wb_pipe_o
);

  logic                          instr_valid;
  logic                          wb_xfer;

  // EX/WB register, control part
  logic                          instr_valid_q;
  logic                          rf_we_q;
  logic                          bch_taken_q;
  // EX/WB register, payload part
  logic [ex_pkg::REG_ADDR_W-1:0] rf_waddr_q;
  logic [ex_pkg::XLEN-1:0]       rf_wdata_q;
  logic [ex_pkg::XLEN-1:0]       pc_q;

  // Kill or halt turns the instruction into a bubble
  assign instr_valid = id_ex_pipe_i.instr_valid && !ctrl_fsm_i.kill_ex && !ctrl_fsm_i.halt_ex;
  assign mul_en_o    = id_ex_pipe_i.mul_en && instr_valid;

  // Result select, forwarded to decode as well
  assign rf_wdata_o = id_ex_pipe_i.mul_en ? mul_result_i : alu_result_i;

  assign branch_decision_o = alu_cmp_i;
  assign branch_target_o   = id_ex_pipe_i.operand_c;

  //////////////////////////////////////////////////
  // Stage handshake
  //////////////////////////////////////////////////

  // ALU is single cycle, multiply waits for the unit
  assign ex_valid_o = instr_valid &&
                      (id_ex_pipe_i.alu_en || (id_ex_pipe_i.mul_en && mul_valid_i));
  assign ex_ready_o = ctrl_fsm_i.kill_ex ||
                      (mul_ready_i && wb_ready_i && !ctrl_fsm_i.halt_ex);

  assign wb_xfer = ex_valid_o && wb_ready_i;

  //////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_valid_q <= 1'b0;
      rf_we_q       <= 1'b0;
      bch_taken_q   <= 1'b0;
    end else if (wb_xfer) begin
      instr_valid_q <= 1'b1;
      rf_we_q       <= id_ex_pipe_i.rf_we;
      bch_taken_q   <= id_ex_pipe_i.bch && branch_decision_o;
    end else if (wb_ready_i) begin
      // WB took the last one and nothing follows
      instr_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wb_xfer) begin
      rf_waddr_q <= id_ex_pipe_i.rf_waddr;
      rf_wdata_q <= rf_wdata_o;
      pc_q       <= id_ex_pipe_i.pc;
    end
  end

  assign ex_wb_pipe_o.instr_valid = instr_valid_q;
  assign ex_wb_pipe_o.rf_we       = rf_we_q;
  assign ex_wb_pipe_o.rf_waddr    = rf_waddr_q;
  assign ex_wb_pipe_o.rf_wdata    = rf_wdata_q;
  assign ex_wb_pipe_o.pc          = pc_q;
  assign ex_wb_pipe_o.bch_taken   = bch_taken_q;

endmodule

/* source/ex_stage.sv */
/*
  Execute stage top: ALU, multiplier and pipeline control
*/
`timescale 1ns/10ps

module ex_stage (
  input  logic                      clk,
  input  logic                      rst_n,
  input  ex_pkg::id_ex_t            id_ex_pipe_i,
  input  ex_pkg::ctrl_fsm_t         ctrl_fsm_i,
  input  logic                      wb_ready_i,
  output ex_pkg::ex_wb_t            ex_wb_pipe_o,
  output logic [ex_pkg::XLEN-1:0]   rf_wdata_o,
  output logic                      branch_decision_o,
  output logic [ex_pkg::XLEN-1:0]   branch_target_o,
  output logic                      ex_valid_o,
  output logic                      ex_ready_o
);

  logic [ex_pkg::XLEN-1:0] alu_result;
  logic                    alu_cmp;
  logic [ex_pkg::XLEN-1:0] mul_result;
  // Gated multiplier enable, drops on kill or halt
  logic                    mul_valid;
  logic                    mul_done;
  logic                    mul_ready;

  //////////////////////////////////////////////////
  // Functional units
  //////////////////////////////////////////////////

  ex_alu alu_i (
    .operator_i   (id_ex_pipe_i.alu_operator),
    .operand_a_i  (id_ex_pipe_i.operand_a),
    .operand_b_i  (id_ex_pipe_i.operand_b),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp)
  );

  // Result is held in the unit until WB takes it
  ex_mult mult_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .operator_i (id_ex_pipe_i.mul_operator),
    .op_a_i     (id_ex_pipe_i.operand_a),
    .op_b_i     (id_ex_pipe_i.operand_b),
    .valid_i    (mul_valid),
    .ready_o    (mul_ready),
    .valid_o    (mul_done),
    .ready_i    (wb_ready_i),
    .result_o   (mul_result)
  );

  //////////////////////////////////////////////////
  // Control and EX/WB register
  //////////////////////////////////////////////////

  ex_pipe_ctrl pipe_ctrl_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .id_ex_pipe_i      (id_ex_pipe_i),
    .ctrl_fsm_i        (ctrl_fsm_i),
    .wb_ready_i        (wb_ready_i),
    .alu_result_i      (alu_result),
    .alu_cmp_i         (alu_cmp),
    .mul_result_i      (mul_result),
    .mul_valid_i       (mul_done),
    .mul_ready_i       (mul_ready),
    .mul_en_o          (mul_valid),
    .branch_decision_o (branch_decision_o),
    .branch_target_o   (branch_target_o),
    .rf_wdata_o        (rf_wdata_o),
    .ex_valid_o        (ex_valid_o),
    .ex_ready_o        (ex_ready_o),
    .ex_wb_pipe_o      (ex_wb_pipe_o)
  );

endmodule

/* tests/ex_stage_chk.sv */
/*
  Concurrent assertions on the EX/WB handshake and reset state,
  bound into every ex_pipe_ctrl instance
*/
`timescale 1ns/10ps

module ex_stage_chk (
  input logic              clk,
  input logic              rst_n,
  input ex_pkg::ctrl_fsm_t ctrl_fsm_i,
  input logic              wb_ready_i,
  input logic              ex_valid_i,
  input ex_pkg::ex_wb_t    ex_wb_pipe_i
);

  // Failed assertion count, read by the testbench at the end
  int fail_count = 0;

  // Register frozen under WB back-pressure
  hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    !wb_ready_i |=> $stable(ex_wb_pipe_i))
    else begin
      $error("EX/WB register changed while wb_ready_i was low");
      fail_count++;
    end

  // Killed instruction never offered to WB
  no_valid_on_kill: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_fsm_i.kill_ex |-> !ex_valid_i)
    else begin
      $error("ex_valid_o high while kill_ex was set");
      fail_count++;
    end

  // First cycle out of reset holds a bubble
  empty_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !ex_wb_pipe_i.instr_valid)
    else begin
      $error("EX/WB instr_valid high in the first cycle after reset");
      fail_count++;
    end

endmodule

bind ex_pipe_ctrl ex_stage_chk chk_i (
  .clk          (clk),
  .rst_n        (rst_n),
  .ctrl_fsm_i   (ctrl_fsm_i),
  .wb_ready_i   (wb_ready_i),
  .ex_valid_i   (ex_valid_o),
  .ex_wb_pipe_i (ex_wb_pipe_o)
);

/* tests/ex_monitor.sv */
/*
  EX/WB monitor: compares each entry taken by WB with the expected queue,
  checks the forwarded result, stage valid and branch target on each hand-off
  and prints the closing count line
*/
`timescale 1ns/10ps

module ex_monitor (
  input logic                    clk,
  input logic                    rst_n,
  input ex_pkg::id_ex_t          id_ex_pipe_i,
  input logic                    wb_ready_i,
  input logic                    ex_valid_i,
  input logic [ex_pkg::XLEN-1:0] rf_wdata_i,
  input ex_pkg::ex_wb_t          ex_wb_pipe_i,
  input logic                    branch_decision_i,
  input logic [ex_pkg::XLEN-1:0] branch_target_i
);

  // Expected WB entries in program order, with the test that queued each
  ex_pkg::ex_wb_t exp_q[$];
  string          name_q[$];
  // Same entries seen from the EX side, popped when the stage hands one to WB
  ex_pkg::ex_wb_t ex_q[$];
  string          ex_name_q[$];
  string          active_test = "none";

  int checked      = 0;
  int mismatches   = 0;
  int other_errors = 0;

  //////////////////////////////////////////////////
  // Calls from the testbench
  //////////////////////////////////////////////////

  function automatic void start_test(input string name);
    active_test = name;
  endfunction

  function automatic void expect_entry(input ex_pkg::ex_wb_t exp);
    exp_q.push_back(exp);
    name_q.push_back(active_test);
    ex_q.push_back(exp);
    ex_name_q.push_back(active_test);
  endfunction

  function automatic void note_failure(input string what);
    other_errors++;
    $display("error: %s", what);
  endfunction

  function automatic int pending_count();
    return exp_q.size();
  endfunction

  function automatic int error_count();
    return mismatches + other_errors;
  endfunction

  function automatic void check_value(input string test, input string field,
                                      input logic [31:0] exp, input logic [31:0] act);
    checked++;
    if (act !== exp) begin
      mismatches++;
      $display("mismatch %s %s expected %h actual %h", test, field, exp, act);
    end
  endfunction

  // Anything still queued never reached WB
  function automatic void final_report(input int assert_fails);
    foreach (name_q[i]) begin
      note_failure($sformatf("no WB result arrived for test %s", name_q[i]));
    end
    $display("monitor: %0d values checked, %0d mismatches, %0d other errors, %0d assertion failures",
             checked, mismatches, other_errors, assert_fails);
  endfunction

  //////////////////////////////////////////////////
  // Sampling at mid cycle
  //////////////////////////////////////////////////

  always @(negedge clk) begin : watch
    ex_pkg::ex_wb_t exp;
    string          test;
    // Stage offers a result, WB takes it at the next rising edge
    if (rst_n && ex_valid_i) begin
      if (ex_q.size() == 0) begin
        note_failure($sformatf("ex_valid_o high with no instruction expected, pc %h",
                               id_ex_pipe_i.pc));
      end else if (wb_ready_i) begin
        exp  = ex_q.pop_front();
        test = ex_name_q.pop_front();
        check_value(test, "rf_wdata_o", exp.rf_wdata, rf_wdata_i);
        // Taken branch must point at operand_c
        if (branch_decision_i) begin
          check_value(test, "branch_target", id_ex_pipe_i.operand_c, branch_target_i);
        end
      end
    end
    // Valid entry with WB ready is taken at the next rising edge
    if (rst_n && ex_wb_pipe_i.instr_valid && wb_ready_i) begin
      if (exp_q.size() == 0) begin
        note_failure($sformatf("WB took an entry nobody expected, pc %h", ex_wb_pipe_i.pc));
      end else begin
        exp  = exp_q.pop_front();
        test = name_q.pop_front();
        check_value(test, "rf_wdata", exp.rf_wdata, ex_wb_pipe_i.rf_wdata);
        check_value(test, "bch_taken", 32'(exp.bch_taken), 32'(ex_wb_pipe_i.bch_taken));
        check_value(test, "rf_we", 32'(exp.rf_we), 32'(ex_wb_pipe_i.rf_we));
        check_value(test, "rf_waddr", 32'(exp.rf_waddr), 32'(ex_wb_pipe_i.rf_waddr));
        check_value(test, "pc", exp.pc, ex_wb_pipe_i.pc);
      end
    end
  end

endmodule

/* tests/ex_tb.sv */
/*
  Execute stage testbench: clock, reset, vectors from tests/ex_input.txt,
  random WB stalls, kill and halt sequencing, DUT and monitor instances
*/
`timescale 1ns/10ps

module ex_tb;

  localparam int    TIMEOUT_CYCLES = 50;
  localparam int    HALT_CYCLES    = 3;
  localparam int    MAX_STALL      = 4;
  localparam string INPUT_FILE     = "tests/ex_input.txt";

  logic                    clk = 1'b0;
  logic                    rst_n;
  ex_pkg::id_ex_t          id_ex_pipe;
  ex_pkg::ctrl_fsm_t       ctrl_fsm;
  logic                    wb_ready;
  ex_pkg::ex_wb_t          ex_wb_pipe;
  logic [ex_pkg::XLEN-1:0] rf_wdata;
  logic                    branch_decision;
  logic [ex_pkg::XLEN-1:0] branch_target;
  logic                    ex_valid;
  logic                    ex_ready;

  always #50 clk = ~clk;

  ex_stage ex_stage_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .id_ex_pipe_i      (id_ex_pipe),
    .ctrl_fsm_i        (ctrl_fsm),
    .wb_ready_i        (wb_ready),
    .ex_wb_pipe_o      (ex_wb_pipe),
    .rf_wdata_o        (rf_wdata),
    .branch_decision_o (branch_decision),
    .branch_target_o   (branch_target),
    .ex_valid_o        (ex_valid),
    .ex_ready_o        (ex_ready)
  );

  ex_monitor mon_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .id_ex_pipe_i      (id_ex_pipe),
    .wb_ready_i        (wb_ready),
    .ex_valid_i        (ex_valid),
    .rf_wdata_i        (rf_wdata),
    .ex_wb_pipe_i      (ex_wb_pipe),
    .branch_decision_i (branch_decision),
    .branch_target_i   (branch_target)
  );

  //////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////

  task automatic drive(input ex_pkg::id_ex_t instr, input ex_pkg::ctrl_fsm_t ctrl,
                       input logic ready);
    @(posedge clk);
    id_ex_pipe <= instr;
    ctrl_fsm   <= ctrl;
    wb_ready   <= ready;
  endtask

  // Hold one vector until the stage accepts it
  task automatic apply_vector(input string name, input ex_pkg::id_ex_t instr,
                              input ex_pkg::ctrl_fsm_t ctrl, input ex_pkg::ex_wb_t exp,
                              output logic ok);
    ex_pkg::ctrl_fsm_t run_ctrl;
    int                stall;
    int                cycle;
    stall    = $urandom % MAX_STALL;
    ok       = 1'b0;
    run_ctrl = ctrl;
    mon_i.start_test(name);
    // Halted first, then released
    if (ctrl.halt_ex) begin
      drive(instr, ctrl, 1'b1);
      repeat (HALT_CYCLES) begin
        @(negedge clk);
        if (ex_ready) begin
          mon_i.note_failure($sformatf("stage accepted %s while halt_ex was set", name));
        end
      end
      run_ctrl.halt_ex = 1'b0;
    end
    // Killed vectors leave nothing in WB
    if (!ctrl.kill_ex) begin
      mon_i.expect_entry(exp);
    end
    drive(instr, run_ctrl, stall == 0);
    for (cycle = 0; cycle < TIMEOUT_CYCLES && !ok; cycle++) begin
      @(negedge clk);
      if (ex_ready) begin
        ok = 1'b1;
      end else begin
        @(posedge clk);
        // WB stall ends after the drawn number of cycles
        if (cycle + 1 >= stall) wb_ready <= 1'b1;
      end
    end
    if (!ok) begin
      mon_i.note_failure($sformatf("timeout, %s not accepted within %0d cycles",
                                   name, TIMEOUT_CYCLES));
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin : main
    int                fd;
    int                fields;
    int                idx;
    int                cycle;
    int                unit;
    int                kill;
    int                halt;
    int                taken;
    int                errors;
    int                assert_fails;
    string             line;
    string             name;
    logic [31:0]       op;
    logic [31:0]       a;
    logic [31:0]       b;
    logic [31:0]       c;
    logic [31:0]       wdata;
    logic              ok;
    ex_pkg::id_ex_t    instr;
    ex_pkg::ctrl_fsm_t ctrl;
    ex_pkg::ex_wb_t    exp;

    rst_n      = 1'b0;
    id_ex_pipe = '0;
    ctrl_fsm   = '0;
    wb_ready   = 1'b1;
    ok         = 1'b1;
    idx        = 0;
    void'($urandom(32'h3748));

    // Two rising edges in reset
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    fd = $fopen(INPUT_FILE, "r");
    if (fd == 0) begin
      mon_i.note_failure("cannot open the vector file");
    end
    while (ok && fd != 0 && !$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) != 0 && line.getc(0) != "#") begin
        fields = $sscanf(line, "%s %d %h %h %h %h %d %d %h %d",
                         name, unit, op, a, b, c, kill, halt, wdata, taken);
        if (fields == 10) begin
          // Decode side of the vector
          instr              = '0;
          instr.instr_valid  = 1'b1;
          instr.alu_en       = (unit == 0);
          instr.mul_en       = (unit == 1);
          instr.alu_operator = ex_pkg::alu_op_e'(op[3:0]);
          instr.mul_operator = ex_pkg::mul_op_e'(op[1:0]);
          instr.bch          = (unit == 0) && (op[3:0] >= ex_pkg::ALU_EQ);
          instr.rf_we        = !instr.bch;
          instr.operand_a    = a;
          instr.operand_b    = b;
          instr.operand_c    = c;
          instr.rf_waddr     = idx[4:0];
          instr.pc           = 32'h1000 + idx * 4;
          ctrl.kill_ex       = (kill != 0);
          ctrl.halt_ex       = (halt != 0);
          // What WB should see
          exp.instr_valid    = 1'b1;
          exp.rf_we          = instr.rf_we;
          exp.rf_waddr       = instr.rf_waddr;
          exp.rf_wdata       = wdata;
          exp.pc             = instr.pc;
          exp.bch_taken      = (taken != 0);
          apply_vector(name, instr, ctrl, exp, ok);
          idx++;
        end else if (fields > 0) begin
          mon_i.note_failure("malformed line in the vector file");
        end
      end
    end
    if (fd != 0) $fclose(fd);
    if (fd != 0 && idx == 0) begin
      mon_i.note_failure("the vector file holds no vectors");
    end

    // Idle inputs and let WB drain
    drive('0, '0, 1'b1);
    for (cycle = 0; cycle < TIMEOUT_CYCLES && mon_i.pending_count() > 0; cycle++) begin
      @(negedge clk);
    end

    assert_fails = ex_stage_i.pipe_ctrl_i.chk_i.fail_count;
    mon_i.final_report(assert_fails);
    errors = mon_i.error_count() + assert_fails;
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* sources.f */
source/ex_pkg.sv
source/ex_alu.sv
source/ex_mult.sv
source/ex_pipe_ctrl.sv
source/ex_stage.sv
tests/ex_stage_chk.sv
tests/ex_monitor.sv
tests/ex_tb.sv

/* Makefile */
# Verilator build and run of the execute stage testbench
SIM       = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = ex_tb
FILELIST  = sources.f
BUILD_DIR = obj_dir
PASS_MSG  = All checks passed

.PHONY: help test clean

help:
	@echo "make help   list the targets"
	@echo "make test   build with $(SIM), run $(TOP), fail unless the pass message is printed"
	@echo "make clean  remove $(BUILD_DIR)"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* tests/ex_input.txt */
# name unit(0 alu, 1 mul) op(hex) operand_a operand_b operand_c kill halt exp_rf_wdata exp_taken
# alu op 0-d add sub and or xor sll srl sra slt sltu eq ne lt ge, mul op 0-2 lo hi_ss hi_uu
add_basic      0 0 00000005 00000007 00000000 0 0 0000000c 0
add_wrap       0 0 ffffffff 00000002 00000000 0 0 00000001 0
sub_neg        0 1 00000003 00000005 00000000 0 0 fffffffe 0
and_mask       0 2 f0f0ff00 0ff0f0f0 00000000 0 0 00f0f000 0
or_bits        0 3 f0000000 0000000f 00000000 0 0 f000000f 0
xor_bits       0 4 aaaa5555 ffff0000 00000000 0 0 55555555 0
sll_31         0 5 00000001 0000001f 00000000 0 0 80000000 0
srl_4          0 6 80000000 00000004 00000000 0 0 08000000 0
sra_4          0 7 80000000 00000004 00000000 0 0 f8000000 0
slt_neg        0 8 ffffffff 00000001 00000000 0 0 00000001 0
sltu_big       0 9 ffffffff 00000001 00000000 0 0 00000000 0
beq_taken      0 a 12345678 12345678 00002000 0 0 00000001 1
bne_not        0 b 00000005 00000005 00002040 0 0 00000000 0
blt_neg        0 c 80000000 00000001 00002080 0 0 00000001 1
bge_not        0 d ffffffff 00000000 000020c0 0 0 00000000 0
bge_taken      0 d 00000005 ffffffff 00002100 0 0 00000001 1
mul_lo         1 0 00001234 00005678 00000000 0 0 06260060 0
mul_lo_neg     1 0 fffffffd 00000007 00000000 0 0 ffffffeb 0
mulh_neg       1 1 fffffffd 00000007 00000000 0 0 ffffffff 0
mulhu_big      1 2 fffffffd 00000007 00000000 0 0 00000006 0
mulh_min       1 1 80000000 80000000 00000000 0 0 40000000 0
mulhu_max      1 2 ffffffff ffffffff 00000000 0 0 fffffffe 0
mul_lo_nn      1 0 fffffffe fffffffe 00000000 0 0 00000004 0
kill_add       0 0 00000001 00000001 00000000 1 0 00000000 0
add_after_kill 0 0 00000010 00000020 00000000 0 0 00000030 0
halt_sub       0 1 00000064 00000001 00000000 0 1 00000063 0
kill_mul       1 0 00000002 00000003 00000000 1 0 00000000 0
mul_after_kill 1 1 ffffffff ffffffff 00000000 0 0 00000000 0
halt_mul       1 0 00010001 00010001 00000000 0 1 00020001 0
add_last       0 0 7fffffff 00000001 00000000 0 0 80000000 0
